/* source/sifhPkg.sv */
`default_nettype none

// shared widths, frame length and types for the photon histogram unit
package sifhPkg;

    // photon timestamp from the TDC
    localparam int timeW = 7;

    // split of the timestamp into coarse and fine fields
    localparam int coarseW = 3; // upper bits, 8 coarse bins
    localparam int fineW   = 4; // lower bits, 16 fine bins

    // events collected before both histograms are scanned
    localparam int eventsPerFrame = 64;

    // a bin can take every event of a frame, so 0 to 64
    localparam int countW = 7;

    // whole timestamp
    typedef logic [timeW-1:0] timestamp_t;

    // coarse bin index, also the upper field of a result
    typedef logic [coarseW-1:0] coarseBin_t;

    // fine bin index, folded over all coarse periods
    typedef logic [fineW-1:0] fineBin_t;

    // one bin count
    typedef logic [countW-1:0] binCount_t;

endpackage

`default_nettype wire

/* source/histIf.sv */
`timescale 1ns/1ps
`default_nettype none

// hits into one histogram builder and its peak result back out
interface histIf #(
    parameter type binT = logic [3:0]
);

    logic               hitValid;  // one cycle per accepted event
    binT                hitBin;
    logic               scanStart; // one cycle at frame end
    logic               scanDone;  // held until next scanStart
    binT                peakBin;
    sifhPkg::binCount_t peakCount;

    // event side, feeds hits and kicks off the scan
    modport ingress (
        output hitValid,
        output hitBin,
        output scanStart
    );

    modport builder (
        input  hitValid,
        input  hitBin,
        input  scanStart,
        output scanDone,
        output peakBin,
        output peakCount
    );

    // result side, only looks at the finished scan
    modport combiner (
        input scanDone,
        input peakBin,
        input peakCount
    );

endinterface

`default_nettype wire

/* source/eventIngress.sv */
`timescale 1ns/1ps
`default_nettype none

// four-phase photon event receiver
// each accepted timestamp becomes one hit in the coarse and one in the fine histogram
module eventIngress (
    input  logic                clk,
    input  logic                res,
    input  logic                eventReq,
    input  sifhPkg::timestamp_t eventTime,
    output logic                eventAck,
    input  logic                frameRelease,
    histIf.ingress              coarse,
    histIf.ingress              fine
);

    typedef enum logic [1:0] {
        idle,        // waiting for eventReq
        ack,         // eventAck high, waiting for eventReq to drop
        holdFrame,   // frame full, scans start here
        waitRelease  // no acks until the combiner is done
    } state_t;

    state_t             state;
    sifhPkg::binCount_t eventCount; // accepted events of this frame
    logic               accept;
    logic               lastEvent;
    logic               hitPulse;
    sifhPkg::coarseBin_t coarseField;
    sifhPkg::fineBin_t   fineField;

    assign accept    = (state == idle) && eventReq;
    assign lastEvent = eventCount == sifhPkg::binCount_t'(sifhPkg::eventsPerFrame);

    // field split of the timestamp
    assign coarseField = eventTime[sifhPkg::timeW-1 -: sifhPkg::coarseW];
    assign fineField   = eventTime[sifhPkg::fineW-1:0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= idle;
            eventAck   <= 1'b0;
            hitPulse   <= 1'b0;
            eventCount <= '0;
        end else begin
            hitPulse <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        eventAck   <= 1'b1;
                        hitPulse   <= 1'b1; // same cycle as the ack rising
                        eventCount <= eventCount + 1'b1;
                        state      <= ack;
                    end
                end
                ack: begin
                    if (!eventReq) begin
                        eventAck <= 1'b0;
                        state    <= lastEvent ? holdFrame : idle;
                    end
                end
                holdFrame: begin
                    eventCount <= '0;
                    state      <= waitRelease;
                end
                waitRelease: begin
                    if (frameRelease) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // bin indices only matter while hitValid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            coarse.hitBin <= coarseField;
            fine.hitBin   <= fineField;
        end
    end

    assign coarse.hitValid = hitPulse;
    assign fine.hitValid   = hitPulse;

    // one cycle, right after the last ack fell
    assign coarse.scanStart = state == holdFrame;
    assign fine.scanStart   = state == holdFrame;

endmodule

`default_nettype wire

/* source/histBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

// one histogram, count per bin, then an argmax scan that empties it again
// bin count follows the width of binT
module histBuilder #(
    parameter type binT = logic [3:0]
) (
    input logic    clk,
    input logic    res,
    histIf.builder hist
);

    sifhPkg::binCount_t binMem [2**$bits(binT)];

    // one extra bit, set once every bin has been visited
    logic [$bits(binT):0] scanIdx;
    logic                 scanning;
    logic                 scanStep; // visiting a bin this cycle
    logic                 scanEnd;  // all bins visited
    binT                  scanBin;
    sifhPkg::binCount_t   scanCount;
    binT                  maxBin;
    sifhPkg::binCount_t   maxCount;

    assign scanStep  = scanning && !scanIdx[$bits(binT)];
    assign scanEnd   = scanning && scanIdx[$bits(binT)];
    assign scanBin   = binT'(scanIdx);
    assign scanCount = binMem[scanBin];

    // counting and scan control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < 2**$bits(binT); i++) begin
                binMem[i] <= '0;
            end
            scanning      <= 1'b0;
            scanIdx       <= '0;
            hist.scanDone <= 1'b0;
        end else if (hist.scanStart) begin
            scanning      <= 1'b1;
            scanIdx       <= '0;
            hist.scanDone <= 1'b0;
        end else if (scanStep) begin
            binMem[scanBin] <= '0; // cleared for the next frame
            scanIdx         <= scanIdx + 1'b1;
        end else if (scanEnd) begin
            scanning      <= 1'b0;
            hist.scanDone <= 1'b1;
        end else if (hist.hitValid) begin
            binMem[hist.hitBin] <= binMem[hist.hitBin] + 1'b1;
        end
    end

    // running maximum over the scan
    always_ff @(posedge clk) begin
        if (hist.scanStart) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (scanStep && (scanCount > maxCount)) begin
            // strict compare keeps the lowest index on a tie
            maxBin   <= scanBin;
            maxCount <= scanCount;
        end
    end

    // result is stable while scanDone is high
    always_ff @(posedge clk) begin
        if (scanEnd) begin
            hist.peakBin   <= maxBin;
            hist.peakCount <= maxCount;
        end
    end

endmodule

`default_nettype wire

/* source/peakCombiner.sv */
`timescale 1ns/1ps
`default_nettype none

// joins coarse and fine peaks into one time-of-flight estimate
// and hands it out over a four-phase req/ack
module peakCombiner (
    input  logic                clk,
    input  logic                res,
    histIf.combiner             coarse,
    histIf.combiner             fine,
    output logic                resultReq,
    output sifhPkg::timestamp_t resultTime,
    output sifhPkg::binCount_t  coarseCount,
    output sifhPkg::binCount_t  fineCount,
    input  logic                resultAck,
    output logic                frameRelease
);

    typedef enum logic [1:0] {
        waitScan,   // both scans still running
        holdReq,    // resultReq high until ack
        waitAckLow,
        rearm       // old scanDone still high, wait for the next frame
    } state_t;

    state_t state;
    logic   bothDone;
    logic   capture;

    assign bothDone = coarse.scanDone && fine.scanDone;
    assign capture  = (state == waitScan) && bothDone;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= waitScan;
            resultReq    <= 1'b0;
            frameRelease <= 1'b0;
        end else begin
            frameRelease <= 1'b0;
            case (state)
                waitScan: begin
                    if (bothDone) begin
                        resultReq <= 1'b1;
                        state     <= holdReq;
                    end
                end
                holdReq: begin
                    if (resultAck) begin
                        resultReq <= 1'b0;
                        state     <= waitAckLow;
                    end
                end
                waitAckLow: begin
                    if (!resultAck) begin
                        frameRelease <= 1'b1; // lets ingress take events again
                        state        <= rearm;
                    end
                end
                rearm: begin
                    // scanDone drops with the next scanStart
                    if (!coarse.scanDone && !fine.scanDone) begin
                        state <= waitScan;
                    end
                end
                default: state <= waitScan;
            endcase
        end
    end

    // result data, held for the whole handshake
    always_ff @(posedge clk) begin
        if (capture) begin
            resultTime  <= {coarse.peakBin, fine.peakBin};
            coarseCount <= coarse.peakCount;
            fineCount   <= fine.peakCount;
        end
    end

endmodule

`default_nettype wire

/* source/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

// single-photon timing histogram unit
// ingress feeds two histograms, the combiner merges their peaks
module sifhTop (
    input  logic                clk,
    input  logic                res,
    // photon events
    input  logic                eventReq,
    input  sifhPkg::timestamp_t eventTime,
    output logic                eventAck,
    // peak result
    output logic                resultReq,
    output sifhPkg::timestamp_t resultTime,
    output sifhPkg::binCount_t  coarseCount,
    output sifhPkg::binCount_t  fineCount,
    input  logic                resultAck
);

    logic frameRelease; // combiner done, next frame may start

    histIf #(.binT(sifhPkg::coarseBin_t)) coarseIf ();
    histIf #(.binT(sifhPkg::fineBin_t))   fineIf ();

    eventIngress ingress (
        .clk          (clk),
        .res          (res),
        .eventReq     (eventReq),
        .eventTime    (eventTime),
        .eventAck     (eventAck),
        .frameRelease (frameRelease),
        .coarse       (coarseIf.ingress),
        .fine         (fineIf.ingress)
    );

    // upper timestamp bits, 8 bins
    histBuilder #(
        .binT (sifhPkg::coarseBin_t)
    ) coarseHist (
        .clk  (clk),
        .res  (res),
        .hist (coarseIf.builder)
    );

    // lower timestamp bits, 16 bins
    histBuilder #(
        .binT (sifhPkg::fineBin_t)
    ) fineHist (
        .clk  (clk),
        .res  (res),
        .hist (fineIf.builder)
    );

    peakCombiner combiner (
        .clk          (clk),
        .res          (res),
        .coarse       (coarseIf.combiner),
        .fine         (fineIf.combiner),
        .resultReq    (resultReq),
        .resultTime   (resultTime),
        .coarseCount  (coarseCount),
        .fineCount    (fineCount),
        .resultAck    (resultAck),
        .frameRelease (frameRelease)
    );

endmodule

`default_nettype wire

/* verif/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

// table-driven testbench for the photon timing histogram unit
// every row is one frame of 64 events, checked against a reference histogram
module sifhTb;

    typedef enum int {
        noiseUniform, // random timestamps over the full range
        noiseFixed,   // cycles through noiseList
        noiseNone     // every event at the peak time
    } noise_t;

    typedef struct {
        string               name;
        sifhPkg::timestamp_t peakTime;
        int                  signalCount; // events at peakTime, the rest is noise
        noise_t              noise;
        int                  ackDelay;    // cycles before resultAck rises
        bit                  earlyNext;   // next frame's first req raised during the delay
    } row_t;

    logic                clk;
    logic                res;
    logic                eventReq;
    sifhPkg::timestamp_t eventTime;
    logic                eventAck;
    logic                resultReq;
    sifhPkg::timestamp_t resultTime;
    sifhPkg::binCount_t  coarseCount;
    sifhPkg::binCount_t  fineCount;
    logic                resultAck;

    row_t                rows [$];
    sifhPkg::timestamp_t stamps [$]; // row r, event k at r * eventsPerFrame + k
    sifhPkg::timestamp_t noiseList [2];
    int                  watchdogNs;

    sifhTop sifhTop_i (
        .clk         (clk),
        .res         (res),
        .eventReq    (eventReq),
        .eventTime   (eventTime),
        .eventAck    (eventAck),
        .resultReq   (resultReq),
        .resultTime  (resultTime),
        .coarseCount (coarseCount),
        .fineCount   (fineCount),
        .resultAck   (resultAck)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("error %s expected %0d (0x%0h) actual %0d (0x%0h)",
                     name, expected, expected, actual, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic addRow(input string name, input sifhPkg::timestamp_t peakTime,
                          input int signalCount, input noise_t noise,
                          input int ackDelay, input bit earlyNext);
        row_t row;
        row.name        = name;
        row.peakTime    = peakTime;
        row.signalCount = signalCount;
        row.noise       = noise;
        row.ackDelay    = ackDelay;
        row.earlyNext   = earlyNext;
        rows.push_back(row);
    endtask

    task automatic loadTable();
        noiseList[0] = 7'h25; // coarse 2, fine 5
        noiseList[1] = 7'h5a; // coarse 5, fine 10
        //      name           peak   sig  noise         delay early
        addRow("strongPeak",   7'h4b, 40, noiseUniform,  2,    1'b0);
        addRow("tieTwoBins",   7'h25, 0,  noiseFixed,    1,    1'b0); // 32 and 32
        addRow("allSame",      7'h3c, 64, noiseNone,     0,    1'b0);
        addRow("backToBack",   7'h12, 30, noiseUniform,  0,    1'b0);
        addRow("slowAck",      7'h66, 36, noiseUniform,  40,   1'b1);
        addRow("carriedEvent", 7'h09, 34, noiseUniform,  5,    1'b0);
        addRow("tieOverPeak",  7'h7f, 20, noiseFixed,    3,    1'b0); // 20 vs 22 and 22
    endtask

    task automatic generateStamps();
        int j;
        foreach (rows[r]) begin
            for (int k = 0; k < sifhPkg::eventsPerFrame; k++) begin
                j = k - rows[r].signalCount;
                if (j < 0 || rows[r].noise == noiseNone) begin
                    stamps.push_back(rows[r].peakTime);
                end else if (rows[r].noise == noiseFixed) begin
                    stamps.push_back(noiseList[j % 2]);
                end else begin
                    stamps.push_back(sifhPkg::timestamp_t'(
                        $urandom_range(0, 2**sifhPkg::timeW - 1)));
                end
            end
        end
    endtask

    // coarse and fine histograms of one row, lowest index wins a tie
    task automatic buildReference(input int r, output int expTime,
                                  output int expCoarse, output int expFine);
        int coarseBins [2**sifhPkg::coarseW];
        int fineBins [2**sifhPkg::fineW];
        int stamp;
        int peakC;
        int peakF;
        foreach (coarseBins[b]) coarseBins[b] = 0;
        foreach (fineBins[b]) fineBins[b] = 0;
        for (int k = 0; k < sifhPkg::eventsPerFrame; k++) begin
            stamp = int'(stamps[r * sifhPkg::eventsPerFrame + k]);
            coarseBins[stamp / (2**sifhPkg::fineW)]++;
            fineBins[stamp % (2**sifhPkg::fineW)]++;
        end
        peakC = 0;
        peakF = 0;
        foreach (coarseBins[b]) if (coarseBins[b] > coarseBins[peakC]) peakC = b;
        foreach (fineBins[b]) if (fineBins[b] > fineBins[peakF]) peakF = b;
        expTime   = peakC * (2**sifhPkg::fineW) + peakF;
        expCoarse = coarseBins[peakC];
        expFine   = fineBins[peakF];
    endtask

    // one full four-phase event handshake
    task automatic sendEvent(input sifhPkg::timestamp_t stamp);
        @(negedge clk);
        eventTime = stamp;
        eventReq  = 1'b1;
        @(negedge clk);
        while (!eventAck) @(negedge clk);
        eventReq = 1'b0;
        @(negedge clk);
        while (eventAck) @(negedge clk);
    endtask

    // waits for the result, checks it and answers after the row's delay
    task automatic collectResult(input int r, input int expTime,
                                 input int expCoarse, input int expFine);
        bit early;
        early = rows[r].earlyNext && (r + 1 < rows.size());
        while (!resultReq) @(negedge clk);
        checkValue({rows[r].name, " resultTime"}, expTime, int'(resultTime));
        checkValue({rows[r].name, " coarseCount"}, expCoarse, int'(coarseCount));
        checkValue({rows[r].name, " fineCount"}, expFine, int'(fineCount));
        for (int i = 0; i < rows[r].ackDelay; i++) begin
            @(negedge clk);
            if (i == 0 && early) begin
                eventTime = stamps[(r + 1) * sifhPkg::eventsPerFrame];
                eventReq  = 1'b1; // 65th request, frame still held
            end
            checkValue({rows[r].name, " eventAck during result delay"}, 0, int'(eventAck));
            checkValue({rows[r].name, " resultReq held"}, 1, int'(resultReq));
        end
        checkValue({rows[r].name, " resultTime held"}, expTime, int'(resultTime));
        resultAck = 1'b1;
        @(negedge clk);
        while (resultReq) begin
            checkValue({rows[r].name, " eventAck before release"}, 0, int'(eventAck));
            @(negedge clk);
        end
        checkValue({rows[r].name, " eventAck before ack low"}, 0, int'(eventAck));
        resultAck = 1'b0;
        if (early) begin
            // held request goes through once the frame is released
            while (!eventAck) @(negedge clk);
            eventReq = 1'b0;
            @(negedge clk);
            while (eventAck) @(negedge clk);
        end
    endtask

    initial begin
        int expTime;
        int expCoarse;
        int expFine;
        int first;
        bit carried;
        void'($urandom(32'ha868c3fe));
        res        = 1'b0;
        eventReq   = 1'b0;
        eventTime  = '0;
        resultAck  = 1'b0;
        watchdogNs = 0;
        loadTable();
        generateStamps();
        watchdogNs = (rows.size() * sifhPkg::eventsPerFrame * 10 + 8) * 40;
        repeat (8) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        checkValue("afterReset eventAck", 0, int'(eventAck));
        checkValue("afterReset resultReq", 0, int'(resultReq));
        carried = 1'b0;
        foreach (rows[r]) begin
            buildReference(r, expTime, expCoarse, expFine);
            first = carried ? 1 : 0; // first event already sent during the last delay
            for (int k = first; k < sifhPkg::eventsPerFrame; k++) begin
                sendEvent(stamps[r * sifhPkg::eventsPerFrame + k]);
            end
            collectResult(r, expTime, expCoarse, expFine);
            carried = rows[r].earlyNext && (r + 1 < rows.size());
        end
        $display("All tests passed");
        $finish;
    end

    // frame budget of 10 cycles per event plus reset
    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("watchdog expired, the DUT stopped answering a handshake");
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* verilog.f */
source/sifhPkg.sv
source/histIf.sv
source/eventIngress.sv
source/histBuilder.sv
source/peakCombiner.sv
source/sifhTop.sv
verif/sifhTb.sv

/* Makefile */
TB_TOP  = sifhTb
RTL_TOP = sifhTop

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir
